// ==== sim/channel_sum_vectors.txt ====
# T name | G gap (cycles or rand) | H beats before a mid-frame reset
# P count ch0 ch1 ch2 ch3 expected_sum (hex binary32, count positions)
T integer_sums
P 8 3f800000 40000000 40400000 40800000 41200000
P 8 40a00000 40c00000 40e00000 41000000 41d00000

T gapped_input
G rand
P 16 3f000000 3fc00000 bf800000 42c80000 42ca0000

# Ties and far-apart exponents, (ch3 + ch1) + (ch2 + ch0)
T rounding
P 6 00000000 33800000 00000000 3f800000 3f800000
P 5 00000000 33800000 00000000 3f800001 3f800002
P 5 00000000 3f800000 00000000 4e800000 4e800000

T signs_cancel_overflow
P 6 bf800000 c0000000 c0400000 c0800000 c1200000
P 4 3f800000 40000000 bf800000 c0000000 00000000
P 3 00000000 7f7fffff 00000000 7f7fffff 7f800000
P 3 00000000 ff7fffff 00000000 ff7fffff ff800000

T back_to_back
G 0
P 16 3f800000 3f800000 3f800000 3f800000 40800000
P 16 40000000 3f000000 3e800000 3e800000 40400000

# Partial frame stops inside channel 2, then reset
T reset_mid_frame
H 40
P 16 41100000 41100000 41100000 41100000 42100000
P 16 3f800000 40000000 40400000 40800000 41200000

// ==== filelist.f ====
source/channel_sum_pkg.sv
source/plane_delay_line.sv
source/fp_adder.sv
source/channel_adder_tree.sv
source/plane_sequencer.sv
source/channel_sum_top.sv
sim/tb_clock_gen.sv
sim/channel_sum_tb.sv

// ==== Makefile ====
TOP = channel_sum_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Everything OK"

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)
	verilator --lint-only -f filelist.f --top-module channel_sum_top

clean:
	rm -rf obj_dir

// ==== sim/channel_sum_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module channel_sum_tb import channel_sum_pkg::*; ();

  localparam int CHANNEL_NUM_IN = 4;
  localparam int PLANE_SIZE     = 16;
  localparam int MAX_WAIT       = 200;
  localparam int LATENCY        = 1 + $clog2(CHANNEL_NUM_IN) * FP_ADD_LATENCY;

  logic        clk;
  logic        por_reset;
  logic        soft_reset;
  logic        reset;
  pixel_beat_t pixel_in;
  sum_beat_t   sum_out;

  fp32_t        exp_sum_q [$];
  pixel_index_t exp_index_q [$];
  int           sent_cycle_q [$];
  fp32_t        frame_pix [PLANE_SIZE][CHANNEL_NUM_IN];
  fp32_t        frame_sum [PLANE_SIZE];
  string        current_test;
  int           cycle = 0;
  int           beat_count;
  int           test_errors;
  int           pass_count;
  int           fail_count;
  int           gap_fixed;
  bit           gap_rand;

  assign reset = por_reset | soft_reset;

  tb_clock_gen #(
    .PERIOD_NS    (20),
    .RESET_CYCLES (10)
  ) tb_clock_gen_inst (
    .clk   (clk),
    .reset (por_reset)
  );

  channel_sum_top #(
    .CHANNEL_NUM_IN (CHANNEL_NUM_IN),
    .PLANE_SIZE     (PLANE_SIZE)
  ) channel_sum_top_inst (
    .clk      (clk),
    .reset    (reset),
    .pixel_in (pixel_in),
    .sum_out  (sum_out)
  );

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  //////////////////////////////////////////////////
  // Compare tasks

  task automatic compare_sum(input fp32_t expected, input fp32_t actual);
    if (expected !== actual) begin
      $display("** Error %s: sum expected %h, actual %h", current_test, expected, actual);
      test_errors++;
    end
  endtask

  task automatic compare_index(input pixel_index_t expected, input pixel_index_t actual);
    if (expected !== actual) begin
      $display("** Error %s: index expected %0d, actual %0d", current_test, expected, actual);
      test_errors++;
    end
  endtask

  task automatic compare_latency(input int expected, input int actual);
    if (expected != actual) begin
      $display("** Error %s: latency expected %0d, actual %0d", current_test, expected, actual);
      test_errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Output monitor, sampled away from the clock edge

  task automatic monitor_outputs();
    forever begin
      @(negedge clk);
      if (!reset && sum_out.valid) begin
        if (exp_sum_q.size() == 0) begin
          $display("%s: output appeared with no result expected", current_test);
          test_errors++;
        end else begin
          compare_sum(exp_sum_q.pop_front(), sum_out.data);
          compare_index(exp_index_q.pop_front(), sum_out.pixel_index);
          compare_latency(LATENCY, cycle - sent_cycle_q.pop_front());
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      pixel_in = '0;
    end
  endtask

  // A nonzero cut stops the frame early and resets the DUT
  task automatic send_frame(input int cut);
    int idx;
    int gap;
    for (int ch = 0; ch < CHANNEL_NUM_IN; ch++) begin
      for (int p = 0; p < PLANE_SIZE; p++) begin
        idx = ch * PLANE_SIZE + p;
        if (cut == 0 || idx < cut) begin
          @(negedge clk);
          pixel_in = '{valid: 1'b1, data: frame_pix[p][ch]};
          if (cut == 0 && ch == CHANNEL_NUM_IN - 1) begin
            exp_sum_q.push_back(frame_sum[p]);
            exp_index_q.push_back(pixel_index_t'(beat_count % PLANE_SIZE));
            sent_cycle_q.push_back(cycle);
          end
          beat_count++;
          gap = gap_rand ? int'($urandom % 6) : gap_fixed;
          idle_cycles(gap);
        end
      end
    end
    if (cut != 0) begin
      @(negedge clk);
      pixel_in   = '0;
      soft_reset = 1'b1;
      repeat (3) @(negedge clk);
      soft_reset = 1'b0;
      beat_count = 0;
    end
  endtask

  task automatic finish_test();
    int waited;
    waited = 0;
    @(negedge clk);
    pixel_in = '0;
    while (exp_sum_q.size() > 0 && waited < MAX_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_sum_q.size() > 0) begin
      $display("%s: no result arrived within %0d cycles, %0d missing",
               current_test, MAX_WAIT, exp_sum_q.size());
      test_errors++;
      exp_sum_q.delete();
      exp_index_q.delete();
      sent_cycle_q.delete();
    end
    if (test_errors == 0) begin
      $display("%s: pass", current_test);
      pass_count++;
    end else begin
      $display("%s: fail with %0d errors", current_test, test_errors);
      fail_count++;
    end
  endtask

  initial begin
    int          fd;
    int          waited;
    int          count;
    int          fill;
    int          cut_next;
    bit          test_open;
    string       tag;
    string       word;
    string       rest;
    logic [31:0] vals [CHANNEL_NUM_IN];
    logic [31:0] sum_word;

    pixel_in     = '0;
    soft_reset   = 1'b0;
    beat_count   = 0;
    test_errors  = 0;
    pass_count   = 0;
    fail_count   = 0;
    gap_fixed    = 0;
    gap_rand     = 1'b0;
    fill         = 0;
    cut_next     = 0;
    test_open    = 1'b0;
    current_test = "startup";
    void'($urandom(62));

    fd = $fopen("sim/channel_sum_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file");
      $display("Something failed");
      $finish;
    end else begin
      // Look only after the first falling edge, once reset is driven
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
      end while (por_reset && waited < MAX_WAIT);
      if (por_reset) begin
        $display("Reset never released");
        $display("Something failed");
        $finish;
      end else begin
        fork
          monitor_outputs();
        join_none

        while ($fscanf(fd, "%s", tag) == 1) begin
          if (tag == "#") begin
            void'($fgets(rest, fd));
          end else if (tag == "T") begin
            if (test_open) begin
              finish_test();
            end else if (test_errors != 0) begin
              $display("%s: fail with %0d errors", current_test, test_errors);
              fail_count++;
            end
            void'($fscanf(fd, "%s", current_test));
            test_errors = 0;
            gap_rand    = 1'b0;
            gap_fixed   = 0;
            test_open   = 1'b1;
          end else if (tag == "G") begin
            void'($fscanf(fd, "%s", word));
            gap_rand  = (word == "rand");
            gap_fixed = gap_rand ? 0 : word.atoi();
          end else if (tag == "H") begin
            void'($fscanf(fd, "%d", cut_next));
          end else if (tag == "P") begin
            void'($fscanf(fd, "%d %h %h %h %h %h", count,
                          vals[0], vals[1], vals[2], vals[3], sum_word));
            repeat (count) begin
              for (int ch = 0; ch < CHANNEL_NUM_IN; ch++) begin
                frame_pix[fill][ch] = vals[ch];
              end
              frame_sum[fill] = sum_word;
              fill++;
              if (fill == PLANE_SIZE) begin
                send_frame(cut_next);
                cut_next = 0;
                fill     = 0;
              end
            end
          end else begin
            $display("Unknown record %s in the vector file", tag);
            test_errors++;
          end
        end
        $fclose(fd);
        if (test_open) begin
          finish_test();
        end

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
          $display("Everything OK");
        end else begin
          $display("Something failed");
        end
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== source/channel_sum_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module channel_sum_top import channel_sum_pkg::*; #(
  parameter int CHANNEL_NUM_IN = 4,
  parameter int PLANE_SIZE     = 16
) (
  input  logic        clk,
  input  logic        reset,
  input  pixel_beat_t pixel_in,
  output sum_beat_t   sum_out
);

  localparam int TREE_LATENCY = $clog2(CHANNEL_NUM_IN) * FP_ADD_LATENCY;

  pixel_beat_t               taps [CHANNEL_NUM_IN];
  logic [CHANNEL_NUM_IN-1:0] tap_valid;
  seq_phase_t                phase;
  pixel_index_t              pixel_index;
  logic                      capture_en;
  logic                      cap_valid;
  fp32_t                     cap_data [CHANNEL_NUM_IN];
  pixel_beat_t               operands [CHANNEL_NUM_IN];
  pixel_index_t              index_pipe [TREE_LATENCY+1];
  pixel_beat_t               total;

  //////////////////////////////////////////////////
  // Delay-line chain, tap k is k planes back

  assign taps[0] = pixel_in;

  for (genvar k = 0; k < CHANNEL_NUM_IN - 1; k++) begin : g_delay
    plane_delay_line #(
      .PLANE_SIZE (PLANE_SIZE)
    ) plane_delay_line_inst (
      .clk      (clk),
      .reset    (reset),
      .beat_in  (taps[k]),
      .beat_out (taps[k + 1])
    );
  end

  plane_sequencer #(
    .CHANNEL_NUM_IN (CHANNEL_NUM_IN),
    .PLANE_SIZE     (PLANE_SIZE)
  ) plane_sequencer_inst (
    .clk         (clk),
    .reset       (reset),
    .beat_valid  (pixel_in.valid),
    .phase       (phase),
    .pixel_index (pixel_index)
  );

  //////////////////////////////////////////////////
  // Capture bank and index pipeline

  assign capture_en = pixel_in.valid && (phase == PH_SUM);

  always_ff @(posedge clk) begin
    if (reset) begin
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= capture_en;
    end
  end

  always_ff @(posedge clk) begin
    if (capture_en) begin
      for (int k = 0; k < CHANNEL_NUM_IN; k++) begin
        cap_data[k] <= taps[k].data;
      end
      index_pipe[0] <= pixel_index;
    end
    // Tree never stalls, so the index just walks alongside
    for (int k = 1; k <= TREE_LATENCY; k++) begin
      index_pipe[k] <= index_pipe[k-1];
    end
  end

  for (genvar k = 0; k < CHANNEL_NUM_IN; k++) begin : g_lane
    assign tap_valid[k] = taps[k].valid;
    assign operands[k]  = '{valid: cap_valid, data: cap_data[k]};
  end

  channel_adder_tree #(
    .CHANNEL_NUM_IN (CHANNEL_NUM_IN)
  ) channel_adder_tree_inst (
    .clk      (clk),
    .reset    (reset),
    .operands (operands),
    .total    (total)
  );

  assign sum_out = '{valid: total.valid, data: total.data,
                     pixel_index: index_pipe[TREE_LATENCY]};

  a_capture_gated: assert property (@(posedge clk) disable iff (reset)
    cap_valid |-> $past(phase == PH_SUM && (&tap_valid)));

endmodule

`default_nettype wire

// ==== source/plane_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module plane_sequencer import channel_sum_pkg::*; #(
  parameter int CHANNEL_NUM_IN = 4,
  parameter int PLANE_SIZE     = 16
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         beat_valid,
  output seq_phase_t   phase,
  output pixel_index_t pixel_index
);

  localparam int CH_W = $clog2(CHANNEL_NUM_IN);

  pixel_index_t    pix_count;
  logic [CH_W-1:0] ch_count;
  logic            plane_end;
  logic            last_channel;

  assign plane_end    = pix_count == pixel_index_t'(PLANE_SIZE - 1);
  assign last_channel = ch_count == CH_W'(CHANNEL_NUM_IN - 1);

  // Counters move only on valid beats
  always_ff @(posedge clk) begin
    if (reset) begin
      pix_count <= '0;
      ch_count  <= '0;
    end else if (beat_valid) begin
      if (plane_end) begin
        pix_count <= '0;
        ch_count  <= last_channel ? '0 : ch_count + 1'b1;
      end else begin
        pix_count <= pix_count + 1'b1;
      end
    end
  end

  // Both describe the beat currently on the input
  assign phase       = last_channel ? PH_SUM : PH_FILL;
  assign pixel_index = pix_count;

  a_index_range: assert property (@(posedge clk) disable iff (reset)
    pixel_index < pixel_index_t'(PLANE_SIZE));

endmodule

`default_nettype wire

// ==== source/channel_adder_tree.sv ====
`timescale 1ns/100ps
`default_nettype none

module channel_adder_tree import channel_sum_pkg::*; #(
  parameter int CHANNEL_NUM_IN = 4
) (
  input  logic        clk,
  input  logic        reset,
  input  pixel_beat_t operands [CHANNEL_NUM_IN],
  output pixel_beat_t total
);

  localparam int LEVELS       = $clog2(CHANNEL_NUM_IN);
  localparam int TREE_LATENCY = LEVELS * FP_ADD_LATENCY;

  // Row 0 holds the operands, row LEVELS the total
  pixel_beat_t lane [LEVELS+1][CHANNEL_NUM_IN];

  if (CHANNEL_NUM_IN < 2 || (CHANNEL_NUM_IN & (CHANNEL_NUM_IN - 1)) != 0) begin : g_bad_count
    $error("CHANNEL_NUM_IN must be a power of two and at least 2");
  end

  for (genvar i = 0; i < CHANNEL_NUM_IN; i++) begin : g_leaf
    assign lane[0][i] = operands[i];
  end

  // Lane i meets lane i+half at every level
  for (genvar l = 0; l < LEVELS; l++) begin : g_level
    localparam int HALF = CHANNEL_NUM_IN >> (l + 1);

    for (genvar i = 0; i < HALF; i++) begin : g_pair
      fp_adder fp_adder_inst (
        .clk   (clk),
        .reset (reset),
        .a     (lane[l][i]),
        .b     (lane[l][i + HALF]),
        .sum   (lane[l + 1][i])
      );
    end
  end

  assign total = lane[LEVELS][0];

  a_tree_latency: assert property (@(posedge clk) disable iff (reset)
    total.valid |-> $past(operands[0].valid, TREE_LATENCY));

endmodule

`default_nettype wire

// ==== source/fp_adder.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_adder import channel_sum_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  pixel_beat_t a,
  input  pixel_beat_t b,
  output pixel_beat_t sum
);

  function automatic logic [4:0] lead_zeros(input logic [26:0] v);
    logic [4:0] n;
    n = 5'd27;
    for (int i = 0; i < 27; i++) begin
      if (v[i]) begin
        n = 5'(26 - i);
      end
    end
    return n;
  endfunction

  logic [FP_ADD_LATENCY-1:0] valid_pipe;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[FP_ADD_LATENCY-2:0], a.valid & b.valid};
    end
  end

  //////////////////////////////////////////////////
  // Stage 1: compare, swap, align

  logic        swap;
  fp32_t       big;
  fp32_t       small_op;
  logic [23:0] small_man;
  logic [7:0]  exp_diff;
  logic [4:0]  shamt;
  logic [49:0] shifted;

  logic        s1_sign;
  logic        s1_sub;
  logic        s1_inf;
  logic [7:0]  s1_exp;
  logic [26:0] s1_big;
  logic [26:0] s1_small;

  assign swap     = {b.data.exponent, b.data.mantissa} > {a.data.exponent, a.data.mantissa};
  assign big      = swap ? b.data : a.data;
  assign small_op = swap ? a.data : b.data;

  // Zero exponent counts as zero
  assign small_man = (small_op.exponent == 8'd0) ? 24'd0 : {1'b1, small_op.mantissa};
  assign exp_diff  = big.exponent - small_op.exponent;

  // Past 26 the whole operand already lands in sticky
  assign shamt   = (exp_diff > 8'd26) ? 5'd26 : exp_diff[4:0];
  assign shifted = {small_man, 26'd0} >> shamt;

  always_ff @(posedge clk) begin
    s1_sign  <= big.sign;
    s1_sub   <= a.data.sign ^ b.data.sign;
    s1_inf   <= (a.data.exponent == 8'hFF) | (b.data.exponent == 8'hFF);
    s1_exp   <= big.exponent;
    s1_big   <= (big.exponent == 8'd0) ? 27'd0 : {1'b1, big.mantissa, 3'b000};
    s1_small <= {shifted[49:24], |shifted[23:0]};
  end

  //////////////////////////////////////////////////
  // Stage 2: add and normalize

  logic [27:0]       raw_sum;
  logic [4:0]        lz;
  logic [26:0]       left_norm;

  logic              s2_sign;
  logic              s2_inf;
  logic              s2_zero;
  logic signed [9:0] s2_exp;
  logic [26:0]       s2_man;

  // Big is never smaller in magnitude, so no negative result
  assign raw_sum = s1_sub ? ({1'b0, s1_big} - {1'b0, s1_small})
                          : ({1'b0, s1_big} + {1'b0, s1_small});
  assign lz        = lead_zeros(raw_sum[26:0]);
  assign left_norm = raw_sum[26:0] << lz;

  always_ff @(posedge clk) begin
    s2_sign <= s1_sign;
    s2_inf  <= s1_inf;
    s2_zero <= raw_sum == 28'd0;
    if (raw_sum[27]) begin
      s2_man <= {raw_sum[27:2], raw_sum[1] | raw_sum[0]};
      s2_exp <= $signed({2'b00, s1_exp}) + 10'sd1;
    end else begin
      s2_man <= left_norm;
      s2_exp <= $signed({2'b00, s1_exp}) - $signed({5'd0, lz});
    end
  end

  //////////////////////////////////////////////////
  // Stage 3: round, flush, overflow

  logic              round_up;
  logic [24:0]       rounded;
  logic signed [9:0] exp_final;
  logic [22:0]       frac_final;
  fp32_t             s3_data;

  // Nearest even on guard, round, sticky
  assign round_up   = s2_man[2] & (s2_man[1] | s2_man[0] | s2_man[3]);
  assign rounded    = {1'b0, s2_man[26:3]} + 25'(round_up);
  assign exp_final  = s2_exp + (rounded[24] ? 10'sd1 : 10'sd0);
  assign frac_final = rounded[24] ? rounded[23:1] : rounded[22:0];

  always_ff @(posedge clk) begin
    if (s2_inf || exp_final >= 10'sd255) begin
      s3_data <= '{sign: s2_sign, exponent: 8'hFF, mantissa: 23'd0};
    end else if (s2_zero || exp_final <= 10'sd0) begin
      s3_data <= '0;
    end else begin
      s3_data <= '{sign: s2_sign, exponent: exp_final[7:0], mantissa: frac_final};
    end
  end

  assign sum = '{valid: valid_pipe[FP_ADD_LATENCY-1], data: s3_data};

  // Tree lanes are paired in step
  a_lanes_in_step: assert property (@(posedge clk) disable iff (reset)
    a.valid == b.valid);

endmodule

`default_nettype wire

// ==== source/plane_delay_line.sv ====
`timescale 1ns/100ps
`default_nettype none

module plane_delay_line import channel_sum_pkg::*; #(
  parameter int PLANE_SIZE = 16
) (
  input  logic        clk,
  input  logic        reset,
  input  pixel_beat_t beat_in,
  output pixel_beat_t beat_out
);

  localparam int FILL_W = $clog2(PLANE_SIZE + 1);

  fp32_t             shift_reg [PLANE_SIZE];
  logic [FILL_W-1:0] fill_count;
  logic              filled;

  // Newest beat sits in entry 0
  always_ff @(posedge clk) begin
    if (beat_in.valid) begin
      shift_reg[0] <= beat_in.data;
      for (int i = 1; i < PLANE_SIZE; i++) begin
        shift_reg[i] <= shift_reg[i-1];
      end
    end
  end

  // Output stays invalid until one full plane has gone in
  always_ff @(posedge clk) begin
    if (reset) begin
      fill_count <= '0;
      filled     <= 1'b0;
    end else if (beat_in.valid && !filled) begin
      if (fill_count == FILL_W'(PLANE_SIZE - 1)) begin
        filled <= 1'b1;
      end else begin
        fill_count <= fill_count + 1'b1;
      end
    end
  end

  assign beat_out = '{valid: beat_in.valid & filled, data: shift_reg[PLANE_SIZE-1]};

  a_data_known: assert property (@(posedge clk) disable iff (reset)
    beat_in.valid |-> !$isunknown(beat_in.data));

endmodule

`default_nettype wire

// ==== source/channel_sum_pkg.sv ====
`default_nettype none

package channel_sum_pkg;

  //////////////////////////////////////////////////
  // Pipeline constants

  // Cycles from operands to result in fp_adder
  localparam int FP_ADD_LATENCY = 3;

  //////////////////////////////////////////////////
  // Stream types

  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] mantissa;
  } fp32_t;

  // Position of a pixel inside one plane
  typedef logic [15:0] pixel_index_t;

  typedef struct packed {
    logic  valid;
    fp32_t data;
  } pixel_beat_t;

  typedef struct packed {
    logic         valid;
    fp32_t        data;
    pixel_index_t pixel_index;
  } sum_beat_t;

  // Sum window is open only while the last channel streams
  typedef enum logic {
    PH_FILL = 1'b0,
    PH_SUM  = 1'b1
  } seq_phase_t;

endpackage

`default_nettype wire
